// ==== Makefile ====
# Verilator build, run, lint and clean for the tiling controller

VERILATOR ?= verilator
TOP       ?= ita_ctrl_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal
LINTFLAGS ?= -Wall --timing --assert
FAIL_MSG  ?= Simulation finished: FAIL

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== include/ita_params.svh ====
////////////////////////////////////////////////////////////
// lane count and tile edge must be powers of two
// ITA_BEATS must stay equal to ITA_M*ITA_M/ITA_N
////////////////////////////////////////////////////////////

`ifndef ITA_PARAMS_SVH
`define ITA_PARAMS_SVH

// datapath geometry
`define ITA_N 4
`define ITA_M 16
`define ITA_BEATS ((`ITA_M * `ITA_M) / `ITA_N)

// output FIFO entries downstream of the engine
`define ITA_FIFO_DEPTH 4

// field widths
`define ITA_WB 24
`define ITA_WC 16
`define ITA_WD 12

`endif

// ==== sim.f ====
+incdir+include
source/ita_cfg_pkg.sv
source/ita_data_pkg.sv
source/tile_sequencer.sv
source/operand_gate.sv
source/edge_padder.sv
source/ita_ctrl_top.sv
tb/tb_clock_gen.sv
tb/ita_ctrl_properties.sv
tb/ita_ctrl_tb.sv

// ==== source/edge_padder.sv ====
////////////////////////////////////////////////////////////
// pads from the index of the beat being accepted
// requant_add_o lags the accepted beat by one cycle
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ita_params.svh"

module edge_padder (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       beat_fire_i,
  input  ita_data_pkg::counter_t     beat_idx_i,
  input  ita_data_pkg::counter_t     tile_x_i,
  input  ita_data_pkg::counter_t     tile_y_i,
  input  logic [`ITA_WD-1:0]         first_outer_i,
  input  logic [`ITA_WD-1:0]         second_outer_i,
  input  ita_data_pkg::bias_t        bias_i,
  input  ita_data_pkg::lane_mask_t   requant_add_i,
  output ita_data_pkg::bias_t        bias_pad_o,
  output ita_data_pkg::lane_mask_t   requant_add_o
);

  ita_data_pkg::counter_t     row;
  ita_data_pkg::counter_t     col_base;
  ita_data_pkg::counter_t     row_lim, col_lim;
  ita_data_pkg::lane_mask_t   keep;
  ita_data_pkg::lane_mask_t   requant_q;

  // beat c covers row c mod M, columns (c div M)*N onward
  assign row = ita_data_pkg::counter_t'(beat_idx_i % `ITA_M)
             + ita_data_pkg::counter_t'(tile_y_i * `ITA_M);
  assign col_base = ita_data_pkg::counter_t'((beat_idx_i / `ITA_M) * `ITA_N)
                  + ita_data_pkg::counter_t'(tile_x_i * `ITA_M);

  assign row_lim = ita_data_pkg::counter_t'(first_outer_i);
  assign col_lim = ita_data_pkg::counter_t'(second_outer_i);

  always_comb begin
    ita_data_pkg::counter_t col_lane;
    keep     = '0;
    col_lane = col_base;
    if (row < row_lim && col_base < col_lim) begin
      for (int i = 0; i < `ITA_N; i++) begin
        col_lane = col_base + ita_data_pkg::counter_t'(i);
        keep[i]  = (col_lane < col_lim); // partial last column group
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `ITA_N; i++) begin
      bias_pad_o[i] = keep[i] ? bias_i[i] : '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      requant_q <= '0;
    end else if (beat_fire_i) begin
      requant_q <= keep & requant_add_i;
    end else begin
      requant_q <= '0; // nothing accepted, no add
    end
  end

  assign requant_add_o = requant_q;

endmodule

// ==== source/ita_cfg_pkg.sv ====
////////////////////////////////////////////////////////////
// only Linear and Feedforward layers are supported
// enum codes follow the full engine's register map
////////////////////////////////////////////////////////////

`include "ita_params.svh"

package ita_cfg_pkg;

  typedef enum logic [1:0] {
    Feedforward = 2'd1,
    Linear      = 2'd2
  } layer_e;

  // codes 1 to 6 belong to attention steps, unused here
  typedef enum logic [3:0] {
    Idle   = 4'd0,
    F1     = 4'd7,
    F2     = 4'd8,
    MatMul = 4'd9
  } step_e;

  typedef struct packed {
    logic             start;      // one-cycle pulse
    layer_e           layer;
    logic [`ITA_WC-1:0] tile_s;   // row tiles
    logic [`ITA_WC-1:0] tile_p;
    logic [`ITA_WC-1:0] tile_e;
    logic [`ITA_WC-1:0] tile_f;
    logic [`ITA_WD-1:0] seq_length;
    logic [`ITA_WD-1:0] proj_space;
    logic [`ITA_WD-1:0] embed_size;
    logic [`ITA_WD-1:0] ff_size;
  } ctrl_t;

endpackage

// ==== source/ita_ctrl_top.sv ====
////////////////////////////////////////////////////////////
// tiling controller for Linear and Feedforward layers
// output handshake is observed only, to return credits
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ita_params.svh"

module ita_ctrl_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  ita_cfg_pkg::ctrl_t       ctrl_i,
  input  logic                     inp_valid_i,
  output logic                     inp_ready_o,
  input  logic                     weight_valid_i,
  output logic                     weight_ready_o,
  input  logic                     bias_valid_i,
  output logic                     bias_ready_o,
  input  logic                     oup_valid_i,
  input  logic                     oup_ready_i,
  input  ita_data_pkg::bias_t      bias_i,
  output ita_data_pkg::bias_t      bias_pad_o,
  input  ita_data_pkg::lane_mask_t requant_add_i,
  output ita_data_pkg::lane_mask_t requant_add_o,
  output ita_cfg_pkg::step_e       step_o,
  output logic                     busy_o,
  output logic                     calc_en_o,
  output ita_data_pkg::counter_t   tile_x_o,
  output ita_data_pkg::counter_t   tile_y_o,
  output ita_data_pkg::counter_t   inner_tile_o,
  output logic                     first_inner_tile_o,
  output logic                     last_inner_tile_o
);

  logic                   active;
  ita_data_pkg::counter_t beat_idx;
  logic [`ITA_WD-1:0]     first_outer, second_outer;

  tile_sequencer u_tile_sequencer (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .ctrl_i             (ctrl_i),
    .beat_fire_i        (calc_en_o),
    .step_o             (step_o),
    .active_o           (active),
    .busy_o             (busy_o),
    .beat_idx_o         (beat_idx),
    .inner_tile_o       (inner_tile_o),
    .tile_x_o           (tile_x_o),
    .tile_y_o           (tile_y_o),
    .first_inner_tile_o (first_inner_tile_o),
    .last_inner_tile_o  (last_inner_tile_o),
    .first_outer_o      (first_outer),
    .second_outer_o     (second_outer)
  );

  operand_gate u_operand_gate (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .inp_valid_i    (inp_valid_i),
    .weight_valid_i (weight_valid_i),
    .bias_valid_i   (bias_valid_i),
    .inp_ready_o    (inp_ready_o),
    .weight_ready_o (weight_ready_o),
    .bias_ready_o   (bias_ready_o),
    .oup_valid_i    (oup_valid_i),
    .oup_ready_i    (oup_ready_i),
    .active_i       (active),
    .last_inner_i   (last_inner_tile_o),
    .calc_en_o      (calc_en_o)
  );

  edge_padder u_edge_padder (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .beat_fire_i    (calc_en_o),
    .beat_idx_i     (beat_idx),
    .tile_x_i       (tile_x_o),
    .tile_y_i       (tile_y_o),
    .first_outer_i  (first_outer),
    .second_outer_i (second_outer),
    .bias_i         (bias_i),
    .requant_add_i  (requant_add_i),
    .bias_pad_o     (bias_pad_o),
    .requant_add_o  (requant_add_o)
  );

endmodule

// ==== source/ita_data_pkg.sv ====
////////////////////////////////////////////////////////////
// lane 0 is the lowest column of a beat
////////////////////////////////////////////////////////////

`include "ita_params.svh"

package ita_data_pkg;

  // beat, tile and occupancy style counters
  typedef logic [`ITA_WC-1:0] counter_t;

  // one bias word per lane
  typedef logic [`ITA_N-1:0][`ITA_WB-1:0] bias_t;

  // keep bit per lane, 1 means inside the matrix
  typedef logic [`ITA_N-1:0] lane_mask_t;

endpackage

// ==== source/operand_gate.sv ====
////////////////////////////////////////////////////////////
// readies and calc_en are combinational on the valids
// one output credit per accepted last-inner-tile beat
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ita_params.svh"

module operand_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic inp_valid_i,
  input  logic weight_valid_i,
  input  logic bias_valid_i,
  output logic inp_ready_o,
  output logic weight_ready_o,
  output logic bias_ready_o,
  input  logic oup_valid_i,
  input  logic oup_ready_i,
  input  logic active_i,
  input  logic last_inner_i,
  output logic calc_en_o
);

  localparam int OccW = $clog2(`ITA_FIFO_DEPTH + 1);

  logic [OccW-1:0] occ_q;
  logic            stall;
  logic            go;
  logic            push, pop;

  assign stall = (occ_q >= OccW'(`ITA_FIFO_DEPTH));
  assign go    = active_i && !stall;

  // cross-coupled readies as in the full engine
  assign inp_ready_o    = go && weight_valid_i;
  assign weight_ready_o = go && inp_valid_i;
  assign bias_ready_o   = go && weight_valid_i;

  assign calc_en_o = go && inp_valid_i && weight_valid_i && bias_valid_i;

  assign push = calc_en_o && last_inner_i;
  assign pop  = oup_valid_i && oup_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else if (push && !pop) begin
      occ_q <= occ_q + 1'b1;
    end else if (pop && !push && occ_q != '0) begin // no credit below empty
      occ_q <= occ_q - 1'b1;
    end
  end

endmodule

// ==== source/tile_sequencer.sv ====
////////////////////////////////////////////////////////////
// tile counts in ctrl_i must be nonzero and held during a run
// start is ignored while a run is in progress
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ita_params.svh"

module tile_sequencer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  ita_cfg_pkg::ctrl_t     ctrl_i,
  input  logic                   beat_fire_i,
  output ita_cfg_pkg::step_e     step_o,
  output logic                   active_o,
  output logic                   busy_o,
  output ita_data_pkg::counter_t beat_idx_o,
  output ita_data_pkg::counter_t inner_tile_o,
  output ita_data_pkg::counter_t tile_x_o,
  output ita_data_pkg::counter_t tile_y_o,
  output logic                   first_inner_tile_o,
  output logic                   last_inner_tile_o,
  output logic [`ITA_WD-1:0]     first_outer_o,
  output logic [`ITA_WD-1:0]     second_outer_o
);

  ita_cfg_pkg::step_e     step_d, step_q;
  ita_data_pkg::counter_t beat_d, beat_q;
  ita_data_pkg::counter_t inner_d, inner_q;
  ita_data_pkg::counter_t tile_x_d, tile_x_q;
  ita_data_pkg::counter_t tile_y_d, tile_y_q;
  ita_data_pkg::counter_t inner_cnt, x_cnt;
  logic busy_q;
  logic last_beat, last_inner, last_x, last_y;

  // loop bounds and matrix extent of the current step
  always_comb begin
    inner_cnt      = ctrl_i.tile_e;
    x_cnt          = ctrl_i.tile_p;
    first_outer_o  = ctrl_i.seq_length;
    second_outer_o = ctrl_i.proj_space;
    case (step_q)
      ita_cfg_pkg::F1: begin
        x_cnt          = ctrl_i.tile_f;
        second_outer_o = ctrl_i.ff_size;
      end
      ita_cfg_pkg::F2: begin
        inner_cnt      = ctrl_i.tile_f; // contracts over the hidden dim
        x_cnt          = ctrl_i.tile_e;
        second_outer_o = ctrl_i.embed_size;
      end
      default: begin
      end
    endcase
  end

  assign last_beat  = (beat_q == ita_data_pkg::counter_t'(`ITA_BEATS - 1));
  assign last_inner = (inner_q == inner_cnt - 1'b1);
  assign last_x     = (tile_x_q == x_cnt - 1'b1);
  assign last_y     = (tile_y_q == ctrl_i.tile_s - 1'b1);

  always_comb begin
    step_d   = step_q;
    beat_d   = beat_q;
    inner_d  = inner_q;
    tile_x_d = tile_x_q;
    tile_y_d = tile_y_q;
    if (step_q == ita_cfg_pkg::Idle) begin
      beat_d   = '0;
      inner_d  = '0;
      tile_x_d = '0;
      tile_y_d = '0;
      if (ctrl_i.start) begin
        if (ctrl_i.layer == ita_cfg_pkg::Linear) begin
          step_d = ita_cfg_pkg::MatMul;
        end else if (ctrl_i.layer == ita_cfg_pkg::Feedforward) begin
          step_d = ita_cfg_pkg::F1;
        end
      end
    end else if (beat_fire_i) begin
      beat_d = beat_q + 1'b1;
      if (last_beat) begin
        beat_d  = '0;
        inner_d = inner_q + 1'b1;
        if (last_inner) begin // output tile done
          inner_d  = '0;
          tile_x_d = tile_x_q + 1'b1;
          if (last_x) begin
            tile_x_d = '0;
            tile_y_d = tile_y_q + 1'b1;
            if (last_y) begin // step done
              tile_y_d = '0;
              if (step_q == ita_cfg_pkg::F1) begin
                step_d = ita_cfg_pkg::F2;
              end else begin
                step_d = ita_cfg_pkg::Idle;
              end
            end
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      step_q   <= ita_cfg_pkg::Idle;
      beat_q   <= '0;
      inner_q  <= '0;
      tile_x_q <= '0;
      tile_y_q <= '0;
      busy_q   <= 1'b0;
    end else begin
      step_q   <= step_d;
      beat_q   <= beat_d;
      inner_q  <= inner_d;
      tile_x_q <= tile_x_d;
      tile_y_q <= tile_y_d;
      busy_q   <= (step_d != ita_cfg_pkg::Idle);
    end
  end

  assign step_o             = step_q;
  assign active_o           = (step_q != ita_cfg_pkg::Idle);
  assign busy_o             = busy_q;
  assign beat_idx_o         = beat_q;
  assign inner_tile_o       = inner_q;
  assign tile_x_o           = tile_x_q;
  assign tile_y_o           = tile_y_q;
  assign first_inner_tile_o = (inner_q == '0);
  assign last_inner_tile_o  = active_o && last_inner;

endmodule

// ==== tb/ita_ctrl_properties.sv ====
////////////////////////////////////////////////////////////
// sampled on the DUT clock
// only the reset check stays armed while rst_ni is low
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ita_ctrl_properties (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               inp_valid_i,
  input logic               weight_valid_i,
  input logic               bias_valid_i,
  input logic               inp_ready_i,
  input logic               weight_ready_i,
  input logic               bias_ready_i,
  input logic               calc_en_i,
  input logic               busy_i,
  input ita_cfg_pkg::step_e step_i
);

  logic any_ready;

  assign any_ready = inp_ready_i || weight_ready_i || bias_ready_i;

  // async reset forces Idle, nothing granted
  reset_quiet: assert property (
    @(posedge clk_i) !rst_ni |-> !any_ready && !calc_en_i && !busy_i
  ) else $error("ready, calc_en or busy high during reset");

  calc_needs_valids: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    calc_en_i |-> inp_valid_i && weight_valid_i && bias_valid_i
  ) else $error("calc_en high without all three operand valids");

  idle_no_ready: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (step_i == ita_cfg_pkg::Idle) |-> !any_ready
  ) else $error("operand ready raised while step is Idle");

endmodule

// ==== tb/ita_ctrl_tb.sv ====
////////////////////////////////////////////////////////////
// random valids and output credits from $urandom, seed 14
// Linear run with a credit stall, then a Feedforward run
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ita_params.svh"

module ita_ctrl_tb;

  localparam int Timeout = 50000; // cycles per wait loop

  logic                     clk;
  logic                     rst_n;
  ita_cfg_pkg::ctrl_t       cfg;
  logic                     inp_valid, weight_valid, bias_valid;
  logic                     inp_ready, weight_ready, bias_ready;
  logic                     oup_valid, oup_ready;
  ita_data_pkg::bias_t      bias, bias_pad, exp_bias;
  ita_data_pkg::lane_mask_t requant_add, requant_out, exp_keep, req_exp_q;
  ita_cfg_pkg::step_e       step;
  logic                     busy, calc_en, first_inner, last_inner;
  ita_data_pkg::counter_t   tile_x, tile_y, inner_tile;
  logic                     oup_hold;
  logic                     exp_go, exp_calc, exp_last_inner, push, pop;
  int                       valid_mode; // 1 all valids high, 2 random
  int                       errors;
  int                       timeouts;
  int                       occ_model;
  int                       held_pushes;
  int                       beat_cnt;
  int                       inner_m;
  int                       tx_m;
  int                       ty_m;
  int                       seed;

  tb_clock_gen u_tb_clock_gen (.clk_o(clk), .rst_no(rst_n));

  ita_ctrl_top u_ita_ctrl_top (
    .clk_i (clk), .rst_ni (rst_n), .ctrl_i (cfg),
    .inp_valid_i (inp_valid), .inp_ready_o (inp_ready),
    .weight_valid_i (weight_valid), .weight_ready_o (weight_ready),
    .bias_valid_i (bias_valid), .bias_ready_o (bias_ready),
    .oup_valid_i (oup_valid), .oup_ready_i (oup_ready),
    .bias_i (bias), .bias_pad_o (bias_pad),
    .requant_add_i (requant_add), .requant_add_o (requant_out),
    .step_o (step), .busy_o (busy), .calc_en_o (calc_en),
    .tile_x_o (tile_x), .tile_y_o (tile_y), .inner_tile_o (inner_tile),
    .first_inner_tile_o (first_inner), .last_inner_tile_o (last_inner)
  );

  bind ita_ctrl_top ita_ctrl_properties u_ita_ctrl_properties (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .inp_valid_i (inp_valid_i), .weight_valid_i (weight_valid_i),
    .bias_valid_i (bias_valid_i), .inp_ready_i (inp_ready_o),
    .weight_ready_i (weight_ready_o), .bias_ready_i (bias_ready_o),
    .calc_en_i (calc_en_o), .busy_i (busy_o), .step_i (step_o)
  );

  // column extent of the output matrix per step
  function automatic int col_limit(input ita_cfg_pkg::ctrl_t c, input ita_cfg_pkg::step_e s);
    if (s == ita_cfg_pkg::F1) return int'(c.ff_size);
    if (s == ita_cfg_pkg::F2) return int'(c.embed_size);
    return int'(c.proj_space);
  endfunction

  // inner tiles per output tile
  function automatic int inner_limit(input ita_cfg_pkg::ctrl_t c, input ita_cfg_pkg::step_e s);
    if (s == ita_cfg_pkg::F2) return int'(c.tile_f);
    return int'(c.tile_e);
  endfunction

  // output tiles per row
  function automatic int x_limit(input ita_cfg_pkg::ctrl_t c, input ita_cfg_pkg::step_e s);
    if (s == ita_cfg_pkg::F1) return int'(c.tile_f);
    if (s == ita_cfg_pkg::F2) return int'(c.tile_e);
    return int'(c.tile_p);
  endfunction

  function automatic ita_data_pkg::lane_mask_t expected_keep(input int beat, input int tx,
                                                             input int ty, input int rows,
                                                             input int cols);
    int                       row;
    int                       base;
    ita_data_pkg::lane_mask_t m;
    row  = (beat % `ITA_M) + ty * `ITA_M;
    base = (beat / `ITA_M) * `ITA_N + tx * `ITA_M;
    m    = '0;
    if (row < rows && base < cols) begin
      for (int i = 0; i < `ITA_N; i++) begin
        m[i] = (base + i < cols);
      end
    end
    return m;
  endfunction

  task automatic report_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
    errors++;
    $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("check failed: %s at %0t", what, $time);
  endtask

  // reference handshake from the valids and the credit model
  assign exp_go   = (step != ita_cfg_pkg::Idle) && (occ_model < `ITA_FIFO_DEPTH);
  assign exp_calc = exp_go && inp_valid && weight_valid && bias_valid;
  assign exp_last_inner = (step != ita_cfg_pkg::Idle)
                       && (inner_m == inner_limit(cfg, step) - 1);
  assign push     = exp_calc && exp_last_inner;
  assign pop      = oup_valid && oup_ready;
  assign exp_keep = expected_keep(beat_cnt, tx_m, ty_m,
                                  int'(cfg.seq_length), col_limit(cfg, step));

  always_comb begin
    for (int i = 0; i < `ITA_N; i++) begin
      exp_bias[i] = exp_keep[i] ? bias[i] : '0;
    end
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      occ_model   <= 0;
      held_pushes <= 0;
      beat_cnt    <= 0;
      inner_m     <= 0;
      tx_m        <= 0;
      ty_m        <= 0;
      req_exp_q   <= '0;
    end else begin
      if (push && !pop) occ_model <= occ_model + 1;
      else if (pop && !push) occ_model <= occ_model - 1;
      if (push && oup_hold) held_pushes <= held_pushes + 1;
      if (step == ita_cfg_pkg::Idle) begin
        beat_cnt <= 0;
        inner_m  <= 0;
        tx_m     <= 0;
        ty_m     <= 0;
      end else if (exp_calc && beat_cnt == `ITA_BEATS - 1) begin
        beat_cnt <= 0;
        if (inner_m == inner_limit(cfg, step) - 1) begin
          inner_m <= 0;
          if (tx_m == x_limit(cfg, step) - 1) begin
            tx_m <= 0;
            ty_m <= (ty_m == int'(cfg.tile_s) - 1) ? 0 : ty_m + 1;
          end else begin
            tx_m <= tx_m + 1;
          end
        end else begin
          inner_m <= inner_m + 1;
        end
      end else if (exp_calc) begin
        beat_cnt <= beat_cnt + 1;
      end
      req_exp_q <= exp_calc ? (exp_keep & requant_add) : '0;
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      assert (inp_ready == (exp_go && weight_valid))
        else report_mismatch("inp_ready_o", inp_ready, exp_go && weight_valid);
      assert (weight_ready == (exp_go && inp_valid))
        else report_mismatch("weight_ready_o", weight_ready, exp_go && inp_valid);
      assert (bias_ready == (exp_go && weight_valid))
        else report_mismatch("bias_ready_o", bias_ready, exp_go && weight_valid);
      assert (calc_en == exp_calc) else report_mismatch("calc_en_o", calc_en, exp_calc);
      assert (busy == (step != ita_cfg_pkg::Idle))
        else report_mismatch("busy_o", busy, step != ita_cfg_pkg::Idle);
      assert (inner_tile == ita_data_pkg::counter_t'(inner_m))
        else report_mismatch("inner_tile_o", inner_tile, inner_m);
      assert (tile_x == ita_data_pkg::counter_t'(tx_m))
        else report_mismatch("tile_x_o", tile_x, tx_m);
      assert (tile_y == ita_data_pkg::counter_t'(ty_m))
        else report_mismatch("tile_y_o", tile_y, ty_m);
      assert (first_inner == (inner_m == 0))
        else report_mismatch("first_inner_tile_o", first_inner, inner_m == 0);
      assert (last_inner == exp_last_inner)
        else report_mismatch("last_inner_tile_o", last_inner, exp_last_inner);
      if (exp_calc) begin
        assert (bias_pad == exp_bias) else report_mismatch("bias_pad_o", bias_pad, exp_bias);
      end
      assert (requant_out == req_exp_q)
        else report_mismatch("requant_add_o", requant_out, req_exp_q);
      assert (held_pushes <= `ITA_FIFO_DEPTH)
        else report_failure("more last-inner beats accepted than output credits");
    end
  end

  // all DUT inputs except ctrl_i change on the falling edge
  initial begin
    seed         = $urandom(14);
    inp_valid    = 1'b0;
    weight_valid = 1'b0;
    bias_valid   = 1'b0;
    oup_valid    = 1'b0;
    oup_ready    = 1'b0;
    bias         = '0;
    requant_add  = '0;
    forever begin
      @(negedge clk);
      inp_valid    = (valid_mode == 2) ? (($urandom % 4) != 0) : (valid_mode == 1);
      weight_valid = (valid_mode == 2) ? (($urandom % 4) != 0) : (valid_mode == 1);
      bias_valid   = (valid_mode == 2) ? (($urandom % 4) != 0) : (valid_mode == 1);
      oup_valid    = (occ_model != 0) && (($urandom % 4) != 0); // FIFO not empty
      oup_ready    = !oup_hold && (($urandom % 4) != 0);
      bias         = {$urandom, $urandom, $urandom};
      requant_add  = ita_data_pkg::lane_mask_t'($urandom);
    end
  end

  task automatic check_idle(input int n);
    repeat (n) begin
      @(posedge clk);
      assert (step == ita_cfg_pkg::Idle) else report_mismatch("step_o", step, ita_cfg_pkg::Idle);
      assert (!busy) else report_mismatch("busy_o", busy, 1'b0);
      assert (!(inp_ready || weight_ready || bias_ready))
        else report_failure("an operand ready is high while idle");
    end
  endtask

  task automatic run_layer(input logic is_ff, input logic hold_credits, input int exp_beats);
    int   beats;
    int   cycles;
    int   stalled;
    logic live;
    logic saw_mm;
    logic saw_f1;
    logic saw_f2;
    beats   = 0;
    cycles  = 0;
    stalled = 0;
    live    = 1'b1;
    saw_mm  = 1'b0;
    saw_f1  = 1'b0;
    saw_f2  = 1'b0;
    @(negedge clk);
    oup_hold  = hold_credits;
    cfg.start = 1'b1;
    @(negedge clk);
    cfg.start = 1'b0;
    assert (busy) else report_failure("busy_o did not rise one cycle after start");
    while (live && cycles < Timeout) begin
      @(posedge clk);
      cycles++;
      live = busy;
      if (calc_en) beats++;
      if (step == ita_cfg_pkg::MatMul) saw_mm = 1'b1;
      if (step == ita_cfg_pkg::F1) saw_f1 = 1'b1;
      if (step == ita_cfg_pkg::F2) begin
        assert (saw_f1) else report_failure("step F2 came before step F1");
        saw_f2 = 1'b1;
      end
      if (oup_hold && occ_model == `ITA_FIFO_DEPTH) begin
        stalled++;
        if (stalled == 16) begin
          @(negedge clk);
          oup_hold = 1'b0; // hand credits back
        end
      end
    end
    if (live) begin
      timeouts++;
      $display("timeout: run still busy after %0d cycles", Timeout);
    end else begin
      assert (beats == exp_beats) else report_mismatch("calc_en_o pulses", beats, exp_beats);
      assert (saw_mm == !is_ff && saw_f1 == is_ff && saw_f2 == is_ff)
        else report_failure("step sequence does not match the layer");
      assert (!hold_credits || stalled >= 16)
        else report_failure("operands never stalled on output credits");
    end
  endtask

  initial begin
    int cycles;
    errors     = 0;
    timeouts   = 0;
    valid_mode = 1;
    oup_hold   = 1'b0;
    cfg        = '0;
    cycles     = 0;
    while (!rst_n && cycles < Timeout) begin
      @(posedge clk);
      cycles++;
    end
    if (!rst_n) begin
      timeouts++;
      $display("timeout: reset was never released");
    end else begin
      check_idle(8);
      @(negedge clk);
      // sizes off the lane and tile grid
      cfg.layer      = ita_cfg_pkg::Linear;
      cfg.tile_s     = 16'd2;
      cfg.tile_p     = 16'd2;
      cfg.tile_e     = 16'd2;
      cfg.tile_f     = 16'd3;
      cfg.seq_length = 12'd27;
      cfg.proj_space = 12'd25;
      cfg.embed_size = 12'd29;
      cfg.ff_size    = 12'd38;
      valid_mode     = 2;
      run_layer(1'b0, 1'b1, int'(cfg.tile_s) * int'(cfg.tile_p) * int'(cfg.tile_e) * `ITA_BEATS);
      if (timeouts == 0) begin
        check_idle(4);
        @(negedge clk);
        cfg.layer = ita_cfg_pkg::Feedforward;
        run_layer(1'b1, 1'b0,
                  2 * int'(cfg.tile_s) * int'(cfg.tile_f) * int'(cfg.tile_e) * `ITA_BEATS);
      end
      if (timeouts == 0) check_idle(4);
    end
    $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb/tb_clock_gen.sv ====
////////////////////////////////////////////////////////////
// 8 ns clock, reset low for the first 10 rising edges
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1; // release away from the active edge
  end

endmodule
